/* hdl/control.sv */
`timescale 1ns/1ps

module control
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  lc3b_types::lc3b_opcode opcode,
    input  logic                   branch_enable,
    output logic                   instr_take,
    output logic                   redirect,
    output logic                   load_ir,
    output logic                   load_regfile,
    output logic                   load_cc,
    output lc3b_types::lc3b_aluop  aluop,
    output logic                   mem_read,
    output logic                   mem_write,
    input  logic                   mem_resp
);

lc3b_types::lc3b_cpu_state state;
lc3b_types::lc3b_cpu_state next_state;

always_ff @(posedge clk) begin
    if (reset) state <= lc3b_types::s_wait_instr;
    else       state <= next_state;
end

always_comb begin
    instr_take   = 1'b0;
    redirect     = 1'b0;
    load_ir      = 1'b0;
    load_regfile = 1'b0;
    load_cc      = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    next_state   = state;
    case (opcode)                       // the alu op follows the opcode in every state.
        lc3b_types::op_add: aluop = lc3b_types::alu_add;
        lc3b_types::op_and: aluop = lc3b_types::alu_and;
        lc3b_types::op_not: aluop = lc3b_types::alu_not;
        default:            aluop = lc3b_types::alu_pass;
    endcase
    case (state)
        lc3b_types::s_wait_instr: begin
            instr_take = instr_valid;   // ir loads in the same cycle the buffer is taken.
            load_ir    = instr_valid;
            if (instr_valid) next_state = lc3b_types::s_decode;
        end
        lc3b_types::s_decode: next_state = lc3b_types::s_execute;
        lc3b_types::s_execute: begin
            case (opcode)
                lc3b_types::op_br: begin
                    redirect   = branch_enable; // a taken branch flushes the prefetch.
                    next_state = lc3b_types::s_wait_instr;
                end
                lc3b_types::op_ldr, lc3b_types::op_str: next_state = lc3b_types::s_mem_access;
                default: next_state = lc3b_types::s_writeback;
            endcase
        end
        lc3b_types::s_mem_access: begin
            mem_read  = (opcode == lc3b_types::op_ldr);
            mem_write = (opcode == lc3b_types::op_str);
            if (mem_resp) begin
                next_state = (opcode == lc3b_types::op_ldr) ? lc3b_types::s_writeback
                                                             : lc3b_types::s_wait_instr;
            end
        end
        lc3b_types::s_writeback: begin
            load_regfile = 1'b1;
            load_cc      = 1'b1;
            next_state   = lc3b_types::s_wait_instr;
        end
        default: next_state = lc3b_types::s_wait_instr;
    endcase
end

// a data response only comes back while exactly one strobe is up in mem_access.
strobe_in_mem_access: assert property (@(posedge clk) disable iff (reset)
    mem_resp |-> (state == lc3b_types::s_mem_access) && (mem_read ^ mem_write));

// the fetch buffer must be empty right after a redirect.
redirect_flushes: assert property (@(posedge clk) disable iff (reset)
    redirect |=> !instr_valid);

endmodule : control

/* hdl/datapath.sv */
`timescale 1ns/1ps
`include "lc3b_params.svh"

module datapath
(
    input  logic                   clk,
    input  logic                   reset,
    input  lc3b_types::lc3b_word   instr,
    input  lc3b_types::lc3b_word   instr_pc,
    input  logic                   load_ir,
    input  logic                   load_regfile,
    input  logic                   load_cc,
    input  lc3b_types::lc3b_aluop  aluop,
    input  logic                   mem_read,
    input  logic                   mem_write,
    output lc3b_types::lc3b_opcode opcode,
    output logic                   branch_enable,
    output lc3b_types::lc3b_word   redirect_pc,
    output logic                   mem_resp,
    lc3b_mem_if.requester          data_port
);

lc3b_types::lc3b_word ir;
lc3b_types::lc3b_word ir_pc;          // fetch address of the instruction in ir.
lc3b_types::lc3b_word mdr;            // load data, held past the resp cycle.
lc3b_types::lc3b_word regfile [`LC3B_NUM_REGS];
logic [2:0]           cc;             // n, z, p.
lc3b_types::lc3b_reg  dest;
lc3b_types::lc3b_reg  sr1;
lc3b_types::lc3b_reg  sr2;
lc3b_types::lc3b_word alu_b;
lc3b_types::lc3b_word alu_out;
lc3b_types::lc3b_word wb_data;

assign opcode = lc3b_types::lc3b_opcode'(ir[15:12]);
assign dest   = ir[11:9];             // also the store source for STR.
assign sr1    = ir[8:6];              // also the base register for LDR and STR.
assign sr2    = ir[2:0];

// bit 5 picks the sign-extended imm5 over the second register.
assign alu_b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regfile[sr2];

always_comb begin
    case (aluop)
        lc3b_types::alu_add: alu_out = regfile[sr1] + alu_b;
        lc3b_types::alu_and: alu_out = regfile[sr1] & alu_b;
        lc3b_types::alu_not: alu_out = ~regfile[sr1];
        default:             alu_out = alu_b;
    endcase
end

assign wb_data = (opcode == lc3b_types::op_ldr) ? mdr : alu_out;

always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < `LC3B_NUM_REGS; i++) regfile[i] <= '0;
        cc <= 3'b010;                   // zero registers read as z.
    end else begin
        if (load_regfile) regfile[dest] <= wb_data;
        if (load_cc) cc <= {wb_data[15], wb_data == 16'd0, !wb_data[15] && wb_data != 16'd0};
    end
end

always_ff @(posedge clk) begin
    if (load_ir) begin
        ir    <= instr;
        ir_pc <= instr_pc;
    end
    if (data_port.resp) mdr <= data_port.rdata;
end

// branch goes to the next pc plus twice the sign-extended offset9.
assign redirect_pc   = ir_pc + 16'd2 + {{6{ir[8]}}, ir[8:0], 1'b0};
assign branch_enable = |(ir[11:9] & cc);

// effective address is base plus twice the sign-extended offset6.
assign data_port.address = regfile[sr1] + {{9{ir[5]}}, ir[5:0], 1'b0};
assign data_port.wdata   = regfile[dest];
assign data_port.read    = mem_read;
assign data_port.write   = mem_write;
assign mem_resp          = data_port.resp;

endmodule : datapath

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`include "lc3b_params.svh"

module fetch_unit
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_take,
    input  logic                 redirect,
    input  lc3b_types::lc3b_word redirect_pc,
    output logic                 instr_valid,
    output lc3b_types::lc3b_word instr,
    output lc3b_types::lc3b_word instr_pc,
    lc3b_mem_if.requester        instr_port
);

lc3b_types::lc3b_word pc;         // next address to fetch.
lc3b_types::lc3b_word req_addr;   // address of the read in flight.
lc3b_types::lc3b_word buf_instr;
lc3b_types::lc3b_word buf_pc;
logic                 buf_valid;
logic                 rd_active;
logic                 discard;    // the read in flight was made stale by a redirect.
logic                 take_fire;
logic                 accept;
logic                 issue;

assign take_fire = instr_take & buf_valid;
assign accept    = instr_port.resp & ~discard & ~redirect;
// a new read starts once the buffer is empty or being emptied this cycle.
assign issue     = ~rd_active & ~redirect & (~buf_valid | take_fire);

always_ff @(posedge clk) begin
    if (reset) begin
        pc        <= `LC3B_RESET_PC;
        buf_valid <= 1'b0;
        rd_active <= 1'b0;
        discard   <= 1'b0;
    end else begin
        if (issue) rd_active <= 1'b1;
        else if (instr_port.resp) rd_active <= 1'b0;

        if (instr_port.resp) discard <= 1'b0;   // the stale result has now been dropped.
        else if (redirect && rd_active) discard <= 1'b1;

        if (redirect) begin
            pc        <= redirect_pc;
            buf_valid <= 1'b0;                  // flush whatever was prefetched.
        end else if (accept) begin
            pc        <= req_addr + 16'd2;
            buf_valid <= 1'b1;
        end else if (take_fire) begin
            buf_valid <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (issue) req_addr <= pc;
    if (accept) begin
        buf_instr <= instr_port.rdata;
        buf_pc    <= req_addr;                 // kept for branch targets.
    end
end

assign instr_port.read    = rd_active;
assign instr_port.write   = 1'b0;             // the instruction side only reads.
assign instr_port.address = req_addr;
assign instr_port.wdata   = '0;
assign instr_valid        = buf_valid;
assign instr              = buf_instr;
assign instr_pc           = buf_pc;

// control may only consume an instruction that is actually buffered.
take_needs_valid: assert property (@(posedge clk) disable iff (reset)
    instr_take |-> instr_valid);

endmodule : fetch_unit

/* hdl/lc3b_mem_if.sv */
`timescale 1ns/1ps

interface lc3b_mem_if;

    logic                 read;     // held high until resp.
    logic                 write;    // never high together with read.
    lc3b_types::lc3b_word address;
    lc3b_types::lc3b_word wdata;
    lc3b_types::lc3b_word rdata;    // valid only in the resp cycle.
    logic                 resp;     // one-cycle completion pulse.

    // the side that asks for a transfer.
    modport requester (
        output read, write, address, wdata,
        input  rdata, resp
    );

    // the side that carries it out and answers.
    modport arbiter (
        input  read, write, address, wdata,
        output rdata, resp
    );

endinterface : lc3b_mem_if

/* hdl/lc3b_params.svh */
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// address of the first instruction fetched after reset.
`define LC3B_RESET_PC 16'h0000

// depth of the register file.
`define LC3B_NUM_REGS 8

// consecutive data grants allowed while a fetch is kept waiting.
`define LC3B_ARB_HOLD 2

`endif

/* hdl/lc3b_types.sv */
package lc3b_types;

typedef logic [15:0] lc3b_word;    // one data or address word.
typedef logic [2:0]  lc3b_reg;     // index into the eight-entry register file.

// only the opcodes this core executes are named, with their LC-3b encodings.
typedef enum logic [3:0] {
    op_br  = 4'b0000,
    op_add = 4'b0001,
    op_and = 4'b0101,
    op_ldr = 4'b0110,
    op_str = 4'b0111,
    op_not = 4'b1001
} lc3b_opcode;

typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_pass    // hands the second operand through unchanged.
} lc3b_aluop;

// core sequencing states.
typedef enum logic [2:0] {
    s_wait_instr,
    s_decode,
    s_execute,
    s_mem_access,
    s_writeback
} lc3b_cpu_state;

// apb master phases, one transfer at a time.
typedef enum logic [1:0] {
    arb_idle,
    arb_setup,
    arb_access
} lc3b_arb_state;

endpackage : lc3b_types

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps
`include "lc3b_params.svh"

module mem_arbiter
(
    input  logic                 clk,
    input  logic                 reset,
    input  lc3b_types::lc3b_word prdata,
    input  logic                 pready,
    lc3b_mem_if.arbiter          instr_port,
    lc3b_mem_if.arbiter          data_port,
    output logic                 psel,
    output logic                 penable,
    output logic                 pwrite,
    output lc3b_types::lc3b_word paddr,
    output lc3b_types::lc3b_word pwdata
);

lc3b_types::lc3b_arb_state state;
logic                      owner_data;     // set while the data port owns the bus.
logic                      resp_q;         // the cycle after completion.
logic [3:0]                hold_cnt;       // data grants taken while fetch waited.
lc3b_types::lc3b_word      rdata_q;
logic                      fetch_req;
logic                      data_req;
logic                      fetch_starved;
logic                      done;

assign fetch_req     = instr_port.read;
assign data_req      = data_port.read | data_port.write;
assign fetch_starved = fetch_req && (hold_cnt >= `LC3B_ARB_HOLD); // fetch must win now.
assign done          = (state == lc3b_types::arb_access) && pready;

always_ff @(posedge clk) begin
    if (reset) begin
        state      <= lc3b_types::arb_idle;
        owner_data <= 1'b0;
        resp_q     <= 1'b0;
        hold_cnt   <= '0;
    end else begin
        resp_q <= done;
        case (state)
            lc3b_types::arb_idle: begin
                // the owner still holds its request while resp is out, so skip a cycle.
                if (!resp_q) begin
                    if (data_req && !fetch_starved) begin
                        owner_data <= 1'b1;
                        state      <= lc3b_types::arb_setup;
                        hold_cnt   <= fetch_req ? hold_cnt + 4'd1 : 4'd0;
                    end else if (fetch_req) begin
                        owner_data <= 1'b0;
                        state      <= lc3b_types::arb_setup;
                        hold_cnt   <= '0;             // fetch served, starvation count restarts.
                    end
                end
            end
            lc3b_types::arb_setup:  state <= lc3b_types::arb_access; // setup is one cycle.
            lc3b_types::arb_access: if (pready) state <= lc3b_types::arb_idle;
            default:                state <= lc3b_types::arb_idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (done) rdata_q <= prdata;           // captured on the completion edge.
end

// the owner keeps its fields stable, so apb is driven straight from them.
assign psel    = (state != lc3b_types::arb_idle);
assign penable = (state == lc3b_types::arb_access);
assign pwrite  = owner_data & data_port.write;
assign paddr   = owner_data ? data_port.address : instr_port.address;
assign pwdata  = data_port.wdata;          // only the data port ever writes.

// only the current owner sees the response.
assign instr_port.resp  = resp_q & ~owner_data;
assign data_port.resp   = resp_q & owner_data;
assign instr_port.rdata = rdata_q;
assign data_port.rdata  = rdata_q;

// an access phase belongs to a selected bus whose owner is still asking.
penable_with_psel: assert property (@(posedge clk) disable iff (reset)
    penable |-> psel && (owner_data ? data_req : fetch_req));

// checks that the owning requester really holds its address until completion.
paddr_stable: assert property (@(posedge clk) disable iff (reset)
    (psel && !(penable && pready)) |=> $stable(paddr));

endmodule : mem_arbiter

/* hdl/mp3.sv */
`timescale 1ns/1ps

module mp3
(
    input  logic                 clk,
    input  logic                 reset,
    input  lc3b_types::lc3b_word prdata,
    input  logic                 pready,
    output logic                 psel,
    output logic                 penable,
    output logic                 pwrite,
    output lc3b_types::lc3b_word paddr,
    output lc3b_types::lc3b_word pwdata
);

lc3b_mem_if instr_port ();            // fetch unit to arbiter.
lc3b_mem_if data_port ();             // datapath to arbiter.

logic                   instr_valid;
lc3b_types::lc3b_word   instr;
lc3b_types::lc3b_word   instr_pc;
logic                   instr_take;
logic                   redirect;
lc3b_types::lc3b_word   redirect_pc;
logic                   load_ir;
logic                   load_regfile;
logic                   load_cc;
lc3b_types::lc3b_aluop  aluop;
logic                   mem_read;
logic                   mem_write;
logic                   mem_resp;
lc3b_types::lc3b_opcode opcode;
logic                   branch_enable;

fetch_unit fetch_unit_module (
    .clk(clk), .reset(reset), .instr_take(instr_take), .redirect(redirect),
    .redirect_pc(redirect_pc), .instr_valid(instr_valid), .instr(instr),
    .instr_pc(instr_pc), .instr_port(instr_port.requester)
);

control control_module (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .opcode(opcode),
    .branch_enable(branch_enable), .instr_take(instr_take), .redirect(redirect),
    .load_ir(load_ir), .load_regfile(load_regfile), .load_cc(load_cc), .aluop(aluop),
    .mem_read(mem_read), .mem_write(mem_write), .mem_resp(mem_resp)
);

datapath datapath_module (
    .clk(clk), .reset(reset), .instr(instr), .instr_pc(instr_pc), .load_ir(load_ir),
    .load_regfile(load_regfile), .load_cc(load_cc), .aluop(aluop), .mem_read(mem_read),
    .mem_write(mem_write), .opcode(opcode), .branch_enable(branch_enable),
    .redirect_pc(redirect_pc), .mem_resp(mem_resp), .data_port(data_port.requester)
);

mem_arbiter arbiter_module (
    .clk(clk), .reset(reset), .prdata(prdata), .pready(pready),
    .instr_port(instr_port.arbiter), .data_port(data_port.arbiter),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata)
);

endmodule : mp3

/* mp3.f */
+incdir+hdl
hdl/lc3b_types.sv
hdl/lc3b_mem_if.sv
hdl/mem_arbiter.sv
hdl/fetch_unit.sv
hdl/datapath.sv
hdl/control.sv
hdl/mp3.sv
testbench/tb_clock.sv
testbench/mp3_tb.sv

/* testbench/mp3_tb.sv */
`timescale 1ns/1ps
`include "lc3b_params.svh"

module mp3_tb;

localparam int NUM_ROWS       = 23;
localparam int TIMEOUT_CYCLES = NUM_ROWS * 30;   // generous for 0 to 3 wait states per transfer.

// one memory word, and the store it should produce when executed (if any).
typedef struct packed {
    lc3b_types::lc3b_word instr_word;
    logic                 has_store;
    lc3b_types::lc3b_word addr;
    lc3b_types::lc3b_word data;
} prog_row;

// row n lands at word n, so its pc is 2*n. r7 is loaded with base 16'h0100 first.
prog_row prog_table [NUM_ROWS] = '{
    '{16'h6E15, 1'b0, 16'h0000, 16'h0000},   // 0: ldr r7, r0, #21.
    '{16'h1226, 1'b0, 16'h0000, 16'h0000},   // 1: add r1, r0, #6.
    '{16'h143D, 1'b0, 16'h0000, 16'h0000},   // 2: add r2, r0, #-3.
    '{16'h1642, 1'b0, 16'h0000, 16'h0000},   // 3: add r3, r1, r2.
    '{16'h77C0, 1'b1, 16'h0100, 16'h0003},   // 4: str r3, r7, #0.
    '{16'h58AC, 1'b0, 16'h0000, 16'h0000},   // 5: and r4, r2, #12.
    '{16'h5A81, 1'b0, 16'h0000, 16'h0000},   // 6: and r5, r2, r1.
    '{16'h79C1, 1'b1, 16'h0102, 16'h000C},   // 7: str r4, r7, #1.
    '{16'h7BC2, 1'b1, 16'h0104, 16'h0004},   // 8: str r5, r7, #2.
    '{16'h9C7F, 1'b0, 16'h0000, 16'h0000},   // 9: not r6, r1, cc becomes n.
    '{16'h7DC3, 1'b1, 16'h0106, 16'hFFF9},   // 10: str r6, r7, #3.
    '{16'h0601, 1'b0, 16'h0000, 16'h0000},   // 11: brzp #1, not taken.
    '{16'h1261, 1'b0, 16'h0000, 16'h0000},   // 12: add r1, r1, #1.
    '{16'h0202, 1'b0, 16'h0000, 16'h0000},   // 13: brp #2, taken.
    '{16'h73C4, 1'b0, 16'h0000, 16'h0000},   // 14: shadow store, never runs.
    '{16'h73C5, 1'b0, 16'h0000, 16'h0000},   // 15: shadow store, never runs.
    '{16'h73C6, 1'b1, 16'h010C, 16'h0007},   // 16: str r1, r7, #6.
    '{16'h6416, 1'b0, 16'h0000, 16'h0000},   // 17: ldr r2, r0, #22.
    '{16'h16BC, 1'b0, 16'h0000, 16'h0000},   // 18: add r3, r2, #-4.
    '{16'h77C7, 1'b1, 16'h010E, 16'h1230},   // 19: str r3, r7, #7.
    '{16'h0FFF, 1'b0, 16'h0000, 16'h0000},   // 20: br #-1, spins here.
    '{16'h0100, 1'b0, 16'h0000, 16'h0000},   // 21: store base.
    '{16'h1234, 1'b0, 16'h0000, 16'h0000}    // 22: load operand.
};

logic                 clk;
logic                 reset;
lc3b_types::lc3b_word prdata;
logic                 pready;
logic                 psel;
logic                 penable;
logic                 pwrite;
lc3b_types::lc3b_word paddr;
lc3b_types::lc3b_word pwdata;

lc3b_types::lc3b_word mem [256];
lc3b_types::lc3b_word fetched [256];       // last word read from each address.
lc3b_types::lc3b_word exp_addr [$];
lc3b_types::lc3b_word exp_data [$];
int                   exp_row [$];          // table row of the STR behind each store.
int                   store_idx;
int                   cycle_count;
int                   wait_left;
logic                 seen_setup;

tb_clock clock_gen (.clk(clk), .reset(reset));

mp3 i_mp3 (
    .clk(clk), .reset(reset), .prdata(prdata), .pready(pready), .psel(psel),
    .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata)
);

task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at time %0t", $time);
endtask

task automatic check_word(input string name, input lc3b_types::lc3b_word actual,
                          input lc3b_types::lc3b_word expected);
    if (actual !== expected) begin
        stop_with_failure($sformatf("MISMATCH %s: got %h, expected %h", name, actual, expected));
    end
endtask

task automatic check_opcode(input string name, input lc3b_types::lc3b_opcode actual,
                            input lc3b_types::lc3b_opcode expected);
    if (actual !== expected) begin
        stop_with_failure($sformatf("MISMATCH %s: got %h, expected %h", name, actual, expected));
    end
endtask

task automatic compare_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        stop_with_failure($sformatf("MISMATCH %s: got %h, expected %h", name, actual, expected));
    end
endtask

// each write must be the next store in table order, issued by the STR at its row.
task automatic match_store();
    if (store_idx >= exp_addr.size()) begin
        stop_with_failure($sformatf("an APB write to %h came after the last expected store", paddr));
    end else begin
        check_word("store paddr", paddr, exp_addr[store_idx]);
        check_word("store pwdata", pwdata, exp_data[store_idx]);
        check_opcode("opcode at store pc",
                     lc3b_types::lc3b_opcode'(fetched[exp_row[store_idx]][15:12]),
                     lc3b_types::op_str);
        store_idx++;
    end
endtask

always @(posedge clk) cycle_count <= cycle_count + 1;

// apb slave. it looks at the phase just after each edge and answers for the next edge.
initial begin
    void'($urandom(32'ha52e_a789));
    pready     = 1'b0;
    prdata     = '0;
    wait_left  = 0;
    seen_setup = 1'b0;
    forever begin
        @(posedge clk);
        #1;
        if (reset) begin
            compare_bit("psel", psel, 1'b0);          // the bus is quiet in reset.
            compare_bit("penable", penable, 1'b0);
            pready = 1'b0;
        end else if (psel && !penable) begin
            if (!seen_setup) begin
                check_word("first paddr", paddr, `LC3B_RESET_PC);
                seen_setup = 1'b1;
            end
            wait_left = $urandom_range(3, 0);        // wait states for this transfer.
            pready    = 1'b0;
        end else if (psel && penable) begin
            if (!seen_setup) begin
                stop_with_failure("an APB access phase came before any setup phase");
            end else if (paddr[15:9] != 7'd0) begin
                stop_with_failure($sformatf("APB access at %h is outside the memory", paddr));
            end else if (wait_left == 0) begin
                pready = 1'b1;                        // completes on the next edge.
                if (pwrite) begin
                    match_store();
                    mem[paddr[8:1]] = pwdata;
                end else begin
                    prdata              = mem[paddr[8:1]];
                    fetched[paddr[8:1]] = mem[paddr[8:1]];
                end
            end else begin
                wait_left = wait_left - 1;
                pready    = 1'b0;
            end
        end else begin
            compare_bit("penable", penable, 1'b0);    // no access phase without psel.
            pready = 1'b0;
        end
    end
end

initial begin
    store_idx   = 0;
    cycle_count = 0;
    // every word outside the program holds a pattern built from its own address.
    for (int i = 0; i < 256; i++) begin
        mem[i]     = {i[7:0], ~i[7:0]};
        fetched[i] = '0;
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
        mem[r] = prog_table[r].instr_word;
        if (prog_table[r].has_store) begin
            exp_addr.push_back(prog_table[r].addr);
            exp_data.push_back(prog_table[r].data);
            exp_row.push_back(r);
        end
    end
    while (store_idx < exp_addr.size() && cycle_count < TIMEOUT_CYCLES) @(posedge clk);
    if (store_idx == exp_addr.size()) begin
        repeat (40) @(posedge clk);                  // the final loop must not store again.
        $display("SIMULATION PASSED");
        $finish;
    end else begin
        stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                                    cycle_count, store_idx, exp_addr.size()));
    end
end

endmodule : mp3_tb

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
(
    output logic clk,
    output logic reset
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;           // 20 ns period.
end

// reset is held for two rising edges and dropped just after the second one.
initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
end

endmodule : tb_clock
